/* list.f */
+incdir+source
source/wsg_pkg.sv
source/wsgRegFile.sv
source/wsgWaveRom.sv
source/wsgVoice.sv
source/wsgOutput.sv
source/wsgSound.sv
testbench/wsgSound_properties.sv
testbench/wsgSound_tb.sv

/* run.sh */
#!/bin/sh
# build and run the wsgSound testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module wsgSound_tb -f list.f -o wsgSound_sim

./obj_dir/wsgSound_sim | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

/* testbench/wsgSound_tb.sv */
`timescale 1ns/1ps
`include "wsg_consts.svh"

module wsgSound_tb import wsgPkg::*; ();

	localparam int seqLen = 34;                    // ticks per stepping run, wraps the table once
	localparam int testTicks = 8 + 12 + 4 * (seqLen + 3) + 8 + (`WSG_BANG_LEN + 14);
	localparam longint watchdogNs = longint'(testTicks) * `WSG_SAMPLE_DIV * 40 * 2;
	localparam logic [14:0] waveRegs = {`WSG_ADDR_WAVE2, `WSG_ADDR_WAVE1, `WSG_ADDR_WAVE0};
	localparam logic [14:0] volRegs  = {`WSG_ADDR_VOL2, `WSG_ADDR_VOL1, `WSG_ADDR_VOL0};

	logic       CCLK;
	logic       rst;
	logic [4:0] addr;
	logic [3:0] data;
	logic       wr;
	logic       bang;
	sndSample_t snd;

	int    checks;
	int    errors;
	int    errStart;
	string curTest;

	wsgSound u_wsgSound (
		.CCLK(CCLK), .rst(rst),
		.addr(addr), .data(data), .wr(wr),
		.bang(bang), .snd(snd)
	);

	initial begin
		CCLK = 1'b0;
		forever #20 CCLK = ~CCLK;
	end

	initial begin
		#(watchdogNs);
		$display("[ERROR] watchdog expired before the tests finished");
		$display("STATUS: FAIL");
		$finish;
	end

	// ------------------------------------------------------------
	// reference model of the wave table and volume scaling
	// ------------------------------------------------------------
	function automatic waveSample_t waveRef(input logic [2:0] wave, input int idx);
		int v;
		case (wave[1:0])
			2'd0:    v = idx / 2;                         // rising saw
			2'd1:    v = (idx < 16) ? 15 : 0;             // square
			2'd2:    v = (idx < 16) ? idx / 2 : (31 - idx) / 2;
			default: v = 15 - idx / 2;                    // falling saw
		endcase
		if (wave[2]) begin
			v = v / 2;                                    // half amplitude set
		end
		return waveSample_t'(v);
	endfunction

	function automatic voiceOut_t scaleByVol(input waveSample_t s, input logic [3:0] vol);
		int p;
		p = int'(s) * int'(vol);
		return voiceOut_t'(p / 16);
	endfunction

	// ------------------------------------------------------------
	// compare tasks and bookkeeping
	// ------------------------------------------------------------
	task automatic checkSnd(input sndSample_t expected, input sndSample_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s: expected 0x%02h, actual 0x%02h", curTest, expected, actual);
		end
	endtask

	task automatic checkSample(input waveSample_t expected, input waveSample_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s: expected 0x%01h, actual 0x%01h", curTest, expected, actual);
		end
	endtask

	task automatic startTest(input string name);
		curTest  = name;
		errStart = errors;
	endtask

	task automatic endTest();
		$display("%s: %s, %0d failures", curTest, (errors == errStart) ? "ok" : "failed",
			errors - errStart);
	endtask

	// ------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------
	task automatic applyReset();
		@(posedge CCLK);
		rst  <= 1'b1;
		wr   <= 1'b0;
		bang <= 1'b0;
		repeat (3) @(posedge CCLK);
		rst <= 1'b0;
	endtask

	task automatic writeReg(input logic [4:0] a, input logic [3:0] d);
		@(posedge CCLK);
		addr <= a;
		data <= d;
		wr   <= 1'b1;
		@(posedge CCLK);
		wr <= 1'b0;
	endtask

	task automatic pulseBang();
		@(posedge CCLK);
		bang <= 1'b1;
		@(posedge CCLK);
		bang <= 1'b0;
	endtask

	// returns in the cycle where tick is high, before the tick edge
	task automatic waitTick();
		do begin
			@(negedge CCLK);
		end while (u_wsgSound.tick !== 1'b1);
	endtask

	// snd settles four edges after the tick edge
	task automatic nextSample(output sndSample_t s);
		waitTick();
		repeat (5) @(negedge CCLK);
		s = snd;
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic testResetIdle();
		sndSample_t s;
		startTest("reset idle");
		applyReset();
		@(negedge CCLK);
		checkSnd(`WSG_IDLE_LEVEL, snd);
		for (int k = 0; k < 5; k++) begin
			nextSample(s);
			checkSnd(`WSG_IDLE_LEVEL, s);
		end
		endTest();
	endtask

	task automatic testStaticVoices();
		sndSample_t  s;
		logic [2:0]  wave;
		logic [3:0]  vol;
		startTest("static volume and wave");
		for (int v = 0; v < 3; v++) begin
			applyReset();
			wave = 3'($urandom % 8);
			vol  = 4'(1 + $urandom % 15);
			writeReg(waveRegs[v * 5 +: 5], {1'b0, wave});
			writeReg(volRegs[v * 5 +: 5], vol);
			nextSample(s);
			nextSample(s);                                // freq 0 keeps index 0
			checkSnd(`WSG_IDLE_LEVEL + scaleByVol(waveRef(wave, 0), vol), s);
		end
		endTest();
	endtask

	task automatic runSequence(input int voice, input logic [2:0] wave);
		sndSample_t s;
		sndSample_t contrib;
		voiceOut_t  expected;
		applyReset();
		waitTick();
		writeReg(waveRegs[voice * 5 +: 5], {1'b0, wave});
		writeReg(volRegs[voice * 5 +: 5], 4'd15);
		if (voice == 0) begin
			writeReg(`WSG_ADDR_FREQ0_N3, 4'h8);          // 0x08000, one index per tick
		end else begin
			writeReg(`WSG_ADDR_FREQ1_N2, 4'h8);          // 0x0800 lands as 0x08000
		end
		for (int k = 1; k <= seqLen; k++) begin
			nextSample(s);
			contrib  = s - `WSG_IDLE_LEVEL;
			expected = scaleByVol(waveRef(wave, k % 32), 4'd15);
			if (contrib[7:4] != 4'h0) begin
				errors++;
				$display("[ERROR] %s: snd 0x%02h is outside the range of one voice", curTest, s);
			end else begin
				checkSample(expected, contrib[3:0]);
			end
		end
	endtask

	task automatic testStepping();
		startTest("stepping frequency");
		runSequence(0, 3'd1);                             // square
		runSequence(0, 3'd2);                             // triangle
		runSequence(0, 3'(4 + $urandom % 4));             // half amplitude set
		runSequence(1, 3'd2);
		endTest();
	endtask

	task automatic testMixUnmapped();
		sndSample_t s;
		sndSample_t expected;
		logic [2:0] wave;
		logic [3:0] vol;
		logic [4:0] a;
		startTest("three voice mix");
		applyReset();
		expected = `WSG_IDLE_LEVEL;
		for (int v = 0; v < 3; v++) begin
			wave = 3'(($urandom % 4) * 2 + 1);            // odd waves start above zero
			vol  = 4'(1 + $urandom % 15);
			writeReg(waveRegs[v * 5 +: 5], {1'b0, wave});
			writeReg(volRegs[v * 5 +: 5], vol);
			expected = expected + scaleByVol(waveRef(wave, 0), vol);
		end
		nextSample(s);
		nextSample(s);
		checkSnd(expected, s);
		for (int n = 0; n < 8; n++) begin
			do begin
				a = 5'($urandom % 16);
			end while (a == `WSG_ADDR_WAVE0 || a == `WSG_ADDR_WAVE1 || a == `WSG_ADDR_WAVE2);
			writeReg(a, 4'($urandom % 16));
		end
		nextSample(s);
		nextSample(s);
		checkSnd(expected, s);                            // unmapped writes change nothing
		endTest();
	endtask

	task automatic testBangBurst();
		sndSample_t s;
		logic       started;
		int         lastActive;
		int         span;
		startTest("bang burst");
		applyReset();
		pulseBang();
		started = 1'b0;
		for (int k = 0; k < 8 && !started; k++) begin
			nextSample(s);
			started = (s != `WSG_IDLE_LEVEL);
		end
		if (!started) begin
			errors++;
			$display("[ERROR] %s: snd never left the idle level after bang", curTest);
		end else begin
			lastActive = 0;
			for (int k = 0; k <= `WSG_BANG_LEN + 4; k++) begin
				if (k > 0) begin
					nextSample(s);
				end
				if (s != `WSG_IDLE_LEVEL) begin
					lastActive = k;
					checks++;
					if (s < `WSG_IDLE_LEVEL - `WSG_ENV_START || s > `WSG_IDLE_LEVEL + `WSG_ENV_START) begin
						errors++;
						$display("[FAIL] %s: expected 0x41..0xBF, actual 0x%02h", curTest, s);
					end
				end
				if (k == 20) begin
					pulseBang();                          // must not restart the burst
				end
			end
			// envelope from 63 down by one every second tick
			span = lastActive + 1;
			checks++;
			if (span < 2 * `WSG_ENV_START - 1 || span > 2 * `WSG_ENV_START + 1) begin
				errors++;
				$display("[FAIL] %s: expected %0d active ticks, actual %0d", curTest,
					2 * `WSG_ENV_START, span);
			end
		end
		endTest();
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		void'($urandom(20));
		rst    = 1'b1;
		addr   = '0;
		data   = '0;
		wr     = 1'b0;
		bang   = 1'b0;
		checks = 0;
		errors = 0;
		repeat (3) @(posedge CCLK);
		rst <= 1'b0;
		testResetIdle();
		testStaticVoices();
		testStepping();
		testMixUnmapped();
		testBangBurst();
		$display("checks run: %0d, failures: %0d", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* testbench/wsgSound_properties.sv */
`timescale 1ns/1ps
`include "wsg_consts.svh"

module wsgSound_properties import wsgPkg::*; (
	input logic         CCLK,
	input logic         rst,
	input logic         bang,
	input logic [7:0]   snd,
	input logic         tick,
	input logic         bangActive,
	input voiceParams_t params0,
	input voiceParams_t params1,
	input voiceParams_t params2
);

	logic [7:0] sinceTick;        // cycles since the last tick
	logic       seenTick;
	logic       quiet;            // no bang and no volume since reset
	logic [8:0] burstTicks;       // ticks spent in the current burst
	logic       volsZero;

	assign volsZero = (params0.vol == 4'd0) && (params1.vol == 4'd0) && (params2.vol == 4'd0);

	always_ff @(posedge CCLK) begin
		if (rst) begin
			sinceTick  <= '0;
			seenTick   <= 1'b0;
			quiet      <= 1'b1;
			burstTicks <= '0;
		end else begin
			sinceTick <= tick ? '0 : sinceTick + 1'b1;
			if (tick) begin
				seenTick   <= 1'b1;
				burstTicks <= bangActive ? burstTicks + 1'b1 : '0;
			end
			if (bang || !volsZero) begin
				quiet <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------
	// tick strobe
	// ------------------------------------------------------------
	tickWidth: assert property (@(posedge CCLK) disable iff (rst) tick |=> !tick)
		else $error("tick held high for more than one cycle");
	tickPeriod: assert property (@(posedge CCLK) disable iff (rst)
		(tick && seenTick) |-> sinceTick == 8'(`WSG_SAMPLE_DIV - 1))
		else $error("tick period differs from the prescaler divide");
	tickAlive: assert property (@(posedge CCLK) disable iff (rst)
		sinceTick <= 8'(`WSG_SAMPLE_DIV))
		else $error("tick missing");

	// ------------------------------------------------------------
	// output level
	// ------------------------------------------------------------
	idleOutput: assert property (@(posedge CCLK) disable iff (rst) quiet |-> snd == `WSG_IDLE_LEVEL)
		else $error("snd left the idle level with no source active");
	burstLength: assert property (@(posedge CCLK) disable iff (rst)
		burstTicks <= 9'(`WSG_BANG_LEN))
		else $error("bang burst lasted longer than its length");

endmodule

bind wsgSound wsgSound_properties u_properties (
	.CCLK(CCLK), .rst(rst), .bang(bang), .snd(snd), .tick(tick),
	.bangActive(u_output.bangActive),
	.params0(params0), .params1(params1), .params2(params2)
);

/* source/wsgSound.sv */
`timescale 1ns/1ps

module wsgSound import wsgPkg::*; (
	input  logic       CCLK,
	input  logic       rst,
	input  logic [4:0] addr,
	input  logic [3:0] data,
	input  logic       wr,
	input  logic       bang,
	output logic [7:0] snd
);

	logic         tick;
	voiceParams_t params0, params1, params2;
	logic [7:0]   waveAddr0, waveAddr1, waveAddr2;
	waveSample_t  waveData0, waveData1, waveData2;
	voiceOut_t    voiceOut0, voiceOut1, voiceOut2;

	// ------------------------------------------------------------
	// control
	// ------------------------------------------------------------
	wsgRegFile u_regFile (
		.CCLK(CCLK), .rst(rst),
		.addr(addr), .data(data), .wr(wr),
		.tick(tick),
		.params0(params0), .params1(params1), .params2(params2)
	);

	wsgWaveRom u_waveRom (
		.CCLK(CCLK),
		.addr0(waveAddr0), .addr1(waveAddr1), .addr2(waveAddr2),
		.data0(waveData0), .data1(waveData1), .data2(waveData2)
	);

	// ------------------------------------------------------------
	// voices and mix
	// ------------------------------------------------------------
	wsgVoice u_voice0 (
		.CCLK(CCLK), .rst(rst), .tick(tick), .params(params0),
		.waveAddr(waveAddr0), .waveData(waveData0), .out(voiceOut0)
	);

	wsgVoice u_voice1 (
		.CCLK(CCLK), .rst(rst), .tick(tick), .params(params1),
		.waveAddr(waveAddr1), .waveData(waveData1), .out(voiceOut1)
	);

	wsgVoice u_voice2 (
		.CCLK(CCLK), .rst(rst), .tick(tick), .params(params2),
		.waveAddr(waveAddr2), .waveData(waveData2), .out(voiceOut2)
	);

	wsgOutput u_output (
		.CCLK(CCLK), .rst(rst), .tick(tick), .bang(bang),
		.out0(voiceOut0), .out1(voiceOut1), .out2(voiceOut2),
		.snd(snd)
	);

endmodule

/* source/wsgOutput.sv */
`timescale 1ns/1ps
`include "wsg_consts.svh"

module wsgOutput import wsgPkg::*; (
	input  logic       CCLK,
	input  logic       rst,
	input  logic       tick,
	input  logic       bang,
	input  voiceOut_t  out0,
	input  voiceOut_t  out1,
	input  voiceOut_t  out2,
	output sndSample_t snd
);

	localparam int cntW = $clog2(`WSG_BANG_LEN);

	logic            bangPend;       // trigger seen and waiting for a tick
	logic            bangActive;
	logic            bangStart;
	logic [14:0]     lfsr;
	logic [cntW-1:0] bangCnt;        // ticks into the burst
	logic [5:0]      env;
	logic [3:0]      tickPipe;
	sndSample_t      bangVal;
	sndSample_t      mixNext;

	assign bangStart = tick && !bangActive && (bangPend || bang);

	// ------------------------------------------------------------
	// bang burst
	// ------------------------------------------------------------
	always_ff @(posedge CCLK) begin
		if (rst) begin
			bangPend   <= 1'b0;
			bangActive <= 1'b0;
			bangCnt    <= '0;
			env        <= '0;
			lfsr       <= 15'h0001;            // any nonzero seed
		end else begin
			if (bangStart) begin
				bangPend <= 1'b0;
			end else if (bang && !bangActive) begin
				bangPend <= 1'b1;               // retrigger while playing is dropped
			end
			if (tick) begin
				lfsr <= {lfsr[13:0], lfsr[14] ^ lfsr[13]};
			end
			if (bangStart) begin
				bangActive <= 1'b1;
				bangCnt    <= '0;
				env        <= 6'(`WSG_ENV_START);
			end else if (tick && bangActive) begin
				bangCnt <= bangCnt + 1'b1;
				if (bangCnt[0] && env != '0) begin
					env <= env - 1'b1;          // decay every second tick
				end
				if (bangCnt == cntW'(`WSG_BANG_LEN - 1)) begin
					bangActive <= 1'b0;
				end
			end
		end
	end

	always_comb begin
		if (!bangActive) begin
			bangVal = `WSG_IDLE_LEVEL;
		end else if (lfsr[0]) begin
			bangVal = `WSG_IDLE_LEVEL + {2'b00, env};
		end else begin
			bangVal = `WSG_IDLE_LEVEL - {2'b00, env};
		end
	end

	// ------------------------------------------------------------
	// output mixer
	// ------------------------------------------------------------
	assign mixNext = bangVal + out0 + out1 + out2;   // peak stays below 0xFF

	always_ff @(posedge CCLK) begin
		if (rst) begin
			tickPipe <= '0;
			snd      <= `WSG_IDLE_LEVEL;
		end else begin
			tickPipe <= {tickPipe[2:0], tick};
			if (tickPipe[3]) begin
				snd <= mixNext;                 // voice outputs settled at t+3
			end
		end
	end

endmodule

/* source/wsgVoice.sv */
`timescale 1ns/1ps
`include "wsg_consts.svh"

module wsgVoice import wsgPkg::*; (
	input  logic         CCLK,
	input  logic         rst,
	input  logic         tick,
	input  voiceParams_t params,
	output logic [7:0]   waveAddr,
	input  waveSample_t  waveData,
	output voiceOut_t    out
);

	logic [`WSG_FREQ_W-1:0] phase;
	logic [`WSG_FREQ_W-1:0] phaseNext;
	logic [2:0]             tickPipe;   // tick delayed by 1, 2 and 3 cycles
	logic [7:0]             product;

	assign phaseNext = phase + params.freq;
	assign product   = waveData * params.vol;

	// ------------------------------------------------------------
	// phase and wave address
	// ------------------------------------------------------------
	// shadow params are settled one cycle after tick
	always_ff @(posedge CCLK) begin
		if (rst) begin
			tickPipe <= '0;
			phase    <= '0;
			waveAddr <= '0;
		end else begin
			tickPipe <= {tickPipe[1:0], tick};
			if (tickPipe[0]) begin
				phase    <= phaseNext;
				waveAddr <= {params.wave, phaseNext[`WSG_FREQ_W-1 -: 5]};  // top 5 bits index
			end
		end
	end

	// ------------------------------------------------------------
	// volume scaling
	// ------------------------------------------------------------
	// ROM data for this tick arrives in the third cycle after it
	always_ff @(posedge CCLK) begin
		if (rst) begin
			out <= '0;
		end else if (tickPipe[2]) begin
			out <= product[7:4];                   // sample * vol / 16
		end
	end

endmodule

/* source/wsgWaveRom.sv */
`timescale 1ns/1ps

module wsgWaveRom import wsgPkg::*; (
	input  logic        CCLK,
	input  logic [7:0]  addr0,
	input  logic [7:0]  addr1,
	input  logic [7:0]  addr2,
	output waveSample_t data0,
	output waveSample_t data1,
	output waveSample_t data2
);

	// ------------------------------------------------------------
	// table generation
	// ------------------------------------------------------------
	// entry {wave, index} sits at bit offset 4 * {wave, index}
	function automatic logic [4*256-1:0] buildTable();
		logic [4*256-1:0] romImage;
		logic [3:0]       value;
		romImage = '0;
		for (int w = 0; w < 8; w++) begin
			for (int i = 0; i < 32; i++) begin
				case (w % 4)
					0:       value = 4'(i / 2);                           // rising saw
					1:       value = (i < 16) ? 4'd15 : 4'd0;             // square
					2:       value = (i < 16) ? 4'(i / 2) : 4'((31 - i) / 2);
					default: value = 4'(15 - i / 2);                      // falling saw
				endcase
				if (w >= 4) begin
					value = value >> 1;                                   // half amplitude set
				end
				romImage[(w * 32 + i) * 4 +: 4] = value;
			end
		end
		return romImage;
	endfunction

	localparam logic [4*256-1:0] romBits = buildTable();

	// ------------------------------------------------------------
	// registered read ports
	// ------------------------------------------------------------
	always_ff @(posedge CCLK) begin
		data0 <= romBits[{addr0, 2'b00} +: 4];
		data1 <= romBits[{addr1, 2'b00} +: 4];
		data2 <= romBits[{addr2, 2'b00} +: 4];
	end

endmodule

/* source/wsgRegFile.sv */
`timescale 1ns/1ps
`include "wsg_consts.svh"

module wsgRegFile import wsgPkg::*; (
	input  logic         CCLK,
	input  logic         rst,
	input  logic [4:0]   addr,
	input  logic [3:0]   data,
	input  logic         wr,
	output logic         tick,
	output voiceParams_t params0,
	output voiceParams_t params1,
	output voiceParams_t params2
);

	logic [`WSG_FREQ_W-1:0] freqHost0;         // voice 0 has the full width
	logic [15:0]            freqHost1;         // upper 16 bits only
	logic [15:0]            freqHost2;
	logic [3:0]             volHost0, volHost1, volHost2;
	logic [2:0]             waveHost0, waveHost1, waveHost2;
	logic [`WSG_DIV_W-1:0]  divCnt;
	logic                   divWrap;

	assign divWrap = (divCnt == `WSG_DIV_W'(`WSG_SAMPLE_DIV - 1));

	// ------------------------------------------------------------
	// sample prescaler and shadow copy
	// ------------------------------------------------------------
	always_ff @(posedge CCLK) begin
		if (rst) begin
			divCnt  <= '0;
			tick    <= 1'b0;
			params0 <= '0;
			params1 <= '0;
			params2 <= '0;
		end else begin
			divCnt <= divWrap ? '0 : divCnt + 1'b1;
			tick   <= divWrap;                     // one cycle per sample
			if (tick) begin
				// voices only ever see whole frequency words
				params0 <= '{freq: freqHost0, vol: volHost0, wave: waveHost0};
				params1 <= '{freq: {freqHost1, 4'b0000}, vol: volHost1, wave: waveHost1};
				params2 <= '{freq: {freqHost2, 4'b0000}, vol: volHost2, wave: waveHost2};
			end
		end
	end

	// ------------------------------------------------------------
	// host nibble writes
	// ------------------------------------------------------------
	always_ff @(posedge CCLK) begin
		if (rst) begin
			freqHost0 <= '0;
			freqHost1 <= '0;
			freqHost2 <= '0;
			volHost0  <= '0;
			volHost1  <= '0;
			volHost2  <= '0;
			waveHost0 <= '0;
			waveHost1 <= '0;
			waveHost2 <= '0;
		end else if (wr) begin
			case (addr)
				`WSG_ADDR_WAVE0:    waveHost0         <= data[2:0];
				`WSG_ADDR_WAVE1:    waveHost1         <= data[2:0];
				`WSG_ADDR_WAVE2:    waveHost2         <= data[2:0];
				`WSG_ADDR_FREQ0_N0: freqHost0[3:0]    <= data;
				`WSG_ADDR_FREQ0_N1: freqHost0[7:4]    <= data;
				`WSG_ADDR_FREQ0_N2: freqHost0[11:8]   <= data;
				`WSG_ADDR_FREQ0_N3: freqHost0[15:12]  <= data;
				`WSG_ADDR_FREQ0_N4: freqHost0[19:16]  <= data;
				`WSG_ADDR_VOL0:     volHost0          <= data;
				`WSG_ADDR_FREQ1_N0: freqHost1[3:0]    <= data;
				`WSG_ADDR_FREQ1_N1: freqHost1[7:4]    <= data;
				`WSG_ADDR_FREQ1_N2: freqHost1[11:8]   <= data;
				`WSG_ADDR_FREQ1_N3: freqHost1[15:12]  <= data;
				`WSG_ADDR_VOL1:     volHost1          <= data;
				`WSG_ADDR_FREQ2_N0: freqHost2[3:0]    <= data;
				`WSG_ADDR_FREQ2_N1: freqHost2[7:4]    <= data;
				`WSG_ADDR_FREQ2_N2: freqHost2[11:8]   <= data;
				`WSG_ADDR_FREQ2_N3: freqHost2[15:12]  <= data;
				`WSG_ADDR_VOL2:     volHost2          <= data;
				default: ;                             // unmapped addresses do nothing
			endcase
		end
	end

endmodule

/* source/wsg_pkg.sv */
`include "wsg_consts.svh"

package wsgPkg;

	// ------------------------------------------------------------
	// sample types along the audio path
	// ------------------------------------------------------------
	typedef logic [3:0] waveSample_t;   // raw wave ROM entry
	typedef logic [3:0] voiceOut_t;     // sample after volume scaling
	typedef logic [7:0] sndSample_t;    // mixed output level

	// ------------------------------------------------------------
	// per-voice parameter set
	// ------------------------------------------------------------
	// frequency is the phase increment per sample tick
	// voices 1 and 2 arrive here already shifted up by four bits
	typedef struct packed {
		logic [`WSG_FREQ_W-1:0] freq;   // phase increment
		logic [3:0]             vol;    // 0 silences the voice
		logic [2:0]             wave;   // wave table select
	} voiceParams_t;

endpackage

/* source/wsg_consts.svh */
`ifndef WSG_CONSTS_SVH
`define WSG_CONSTS_SVH

// ------------------------------------------------------------
// timing and sizes
// ------------------------------------------------------------
`define WSG_SAMPLE_DIV   32      // CCLK cycles per sample tick
`define WSG_DIV_W        6       // prescaler counter width
`define WSG_BANG_LEN     128     // burst length in sample ticks
`define WSG_ENV_START    63      // initial burst envelope
`define WSG_IDLE_LEVEL   8'h80   // output midpoint
`define WSG_FREQ_W       20      // phase accumulator width

// ------------------------------------------------------------
// host register map
// ------------------------------------------------------------
`define WSG_ADDR_WAVE0     5'h05
`define WSG_ADDR_WAVE1     5'h0A
`define WSG_ADDR_WAVE2     5'h0F

`define WSG_ADDR_FREQ0_N0  5'h10
`define WSG_ADDR_FREQ0_N1  5'h11
`define WSG_ADDR_FREQ0_N2  5'h12
`define WSG_ADDR_FREQ0_N3  5'h13
`define WSG_ADDR_FREQ0_N4  5'h14
`define WSG_ADDR_VOL0      5'h15

`define WSG_ADDR_FREQ1_N0  5'h16
`define WSG_ADDR_FREQ1_N1  5'h17
`define WSG_ADDR_FREQ1_N2  5'h18
`define WSG_ADDR_FREQ1_N3  5'h19
`define WSG_ADDR_VOL1      5'h1A

`define WSG_ADDR_FREQ2_N0  5'h1B
`define WSG_ADDR_FREQ2_N1  5'h1C
`define WSG_ADDR_FREQ2_N2  5'h1D
`define WSG_ADDR_FREQ2_N3  5'h1E
`define WSG_ADDR_VOL2      5'h1F

`endif
